/* project.f */
+incdir+include
verilog/mipsExecPkg.sv
verilog/creditQueue.sv
verilog/instrDecoder.sv
verilog/intAlu.sv
verilog/hiLoUnit.sv
verilog/memAddrUnit.sv
verilog/execStage.sv
testbench/execStageTb.sv

/* include/execRefModel.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Expected ALU value with MIPS immediate rules
function automatic logic [31:0] refAlu(input logic [31:0] instr, input logic [31:0] rs,
		input logic [31:0] rt);
	logic [5:0] op;
	logic [5:0] fn;
	logic [31:0] se;
	logic [31:0] ze;
	op = instr[31:26];
	fn = instr[5:0];
	se = {{16{instr[15]}}, instr[15:0]};
	ze = {16'h0000, instr[15:0]};
	if (op == OP_SPECIAL) begin
		case (fn)
			FN_ADDU: return rs + rt;
			FN_SUBU: return rs - rt;
			FN_AND: return rs & rt;
			FN_OR: return rs | rt;
			FN_XOR: return rs ^ rt;
			FN_SLT: return {31'b0, $signed(rs) < $signed(rt)};
			FN_SLTU: return {31'b0, rs < rt};
			FN_SLL: return rt << instr[10:6];
			FN_SRL: return rt >> instr[10:6];
			FN_SRA: return $signed(rt) >>> instr[10:6];
			FN_SLLV: return rt << rs[4:0];
			FN_SRLV: return rt >> rs[4:0];
			FN_SRAV: return $signed(rt) >>> rs[4:0];
			default: return '0;
		endcase
	end
	case (op)
		OP_ADDIU: return rs + se;
		OP_SLTI: return {31'b0, $signed(rs) < $signed(se)};
		OP_SLTIU: return {31'b0, rs < se};
		OP_ANDI: return rs & ze;
		OP_ORI: return rs | ze;
		OP_XORI: return rs ^ ze;
		OP_LUI: return {instr[15:0], 16'h0000};
		default: return '0;
	endcase
endfunction

// Aligned address, byte enables and address error of a load or store
function automatic void refMem(input logic [31:0] instr, input logic [31:0] rs,
		output logic [31:0] addr, output logic [3:0] be, output logic err);
	logic [31:0] ea;
	logic [5:0] op;
	ea = rs + {{16{instr[15]}}, instr[15:0]};
	op = instr[31:26];
	addr = {ea[31:2], 2'b00};
	err = 1'b0;
	case (op)
		OP_LB, OP_LBU, OP_SB: be = 4'b0001 << ea[1:0];
		OP_LH, OP_LHU, OP_SH: begin
			err = ea[1:0] == 2'd3;
			be = err ? 4'b0000 : (4'b0011 << ea[1:0]);
		end
		OP_LWL: be = 4'b1111 << ea[1:0];
		OP_LWR: be = 4'b1111 >> (2'd3 - ea[1:0]);
		default: be = 4'b1111;
	endcase
endfunction

// HI/LO shadow update, returns the mfhi or mflo value
function automatic logic [31:0] refHiLo(input logic [31:0] instr, input logic [31:0] rs,
		input logic [31:0] rt, inout logic [31:0] hi, inout logic [31:0] lo);
	case (instr[5:0])
		FN_MFHI: return hi;
		FN_MFLO: return lo;
		FN_MTHI: hi = rs;
		FN_MTLO: lo = rs;
		FN_MULT: {hi, lo} = $signed(rs) * $signed(rt);
		FN_MULTU: {hi, lo} = rs * rt;
		FN_DIV, FN_DIVU: begin
			if (rt == '0) begin
				lo = '1;
				hi = rs;
			end else if (instr[0] == 1'b0) begin
				lo = $signed(rs) / $signed(rt);
				hi = $signed(rs) % $signed(rt);
			end else begin
				lo = rs / rt;
				hi = rs % rt;
			end
		end
		default: ;
	endcase
	return '0;
endfunction

`endif

/* testbench/execStageTb.sv */
`timescale 1ns/1ps

module execStageTb import mipsExecPkg::*; ();

	localparam int IN_DEPTH = 4;
	localparam int RES_DEPTH = 4;
	localparam int OUT_CREDITS = 3;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_INSTR = 400;

	logic clk;
	logic arstN;
	logic inValid;
	issueT inIssue;
	logic inCreditReturn;
	logic outValid;
	resultT outResult;
	logic outCreditReturn;

	int seed = 21760;
	int gapSeed = 21760; // Separate stream for the downstream side
	int inCredits;
	int beatsSent;
	int returnsSeen;
	int outMirror;
	logic prevRet;
	int owed;
	int stall;
	logic [7:0] nextTag;
	dataT shadowHi;
	dataT shadowLo;
	resultT expQ[$];

	logic [5:0] aluFns [13] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
		FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
	logic [5:0] immOps [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	logic [5:0] hlFns [8] = '{FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU,
		FN_DIV, FN_DIVU};
	logic [5:0] mulDivFns [4] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};
	logic [5:0] memOps [10] = '{OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR,
		OP_SB, OP_SH, OP_SW};

	`include "execRefModel.svh"

	execStage #(
		.IN_DEPTH(IN_DEPTH),
		.RES_DEPTH(RES_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) u_execStage (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inIssue(inIssue),
		.inCreditReturn(inCreditReturn),
		.outValid(outValid),
		.outResult(outResult),
		.outCreditReturn(outCreditReturn)
	);

	always #5 clk = ~clk;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkField(input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want)
		else failRun($sformatf("ERR %s exp 0x%h got 0x%h", name, want, got));
	endtask

	function automatic dataT randWord();
		return $random(seed);
	endfunction

	function automatic dataT rType(input logic [5:0] fn, input logic [4:0] sa);
		return {OP_SPECIAL, 5'd3, 5'd4, 5'd5, sa, fn};
	endfunction

	function automatic dataT iType(input logic [5:0] op, input logic [15:0] imm);
		return {op, 5'd3, 5'd4, imm};
	endfunction

	function automatic opClassT classOf(input dataT instr);
		logic [5:0] op;
		logic [5:0] fn;
		op = instr[31:26];
		fn = instr[5:0];
		if (op == OP_SPECIAL) begin
			if (fn inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV})
				return CLASS_ALU;
			if (fn inside {FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU,
					FN_DIV, FN_DIVU})
				return CLASS_HILO;
			return CLASS_ILLEGAL;
		end
		if (op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
			return CLASS_ALU;
		if (op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR,
				OP_SB, OP_SH, OP_SW})
			return CLASS_MEM;
		return CLASS_ILLEGAL;
	endfunction

	// Also advances the HI/LO shadow, so call in issue order
	function automatic resultT expectedResult(input issueT iss);
		resultT r;
		dataT addr;
		logic [3:0] be;
		logic err;
		r = '0;
		r.tag = iss.tag;
		case (classOf(iss.instr))
			CLASS_ALU: begin
				r.value = refAlu(iss.instr, iss.rsVal, iss.rtVal);
				r.writesReg = 1'b1;
			end
			CLASS_HILO: begin
				r.value = refHiLo(iss.instr, iss.rsVal, iss.rtVal, shadowHi, shadowLo);
				r.writesReg = iss.instr[5:0] inside {FN_MFHI, FN_MFLO};
			end
			CLASS_MEM: begin
				refMem(iss.instr, iss.rsVal, addr, be, err);
				r.value = addr;
				r.byteEnable = be;
				r.memAccess = 1'b1;
				r.addrError = err;
				r.writesReg = !(iss.instr[31:26] inside {OP_SB, OP_SH, OP_SW}); // Loads only
			end
			default: r.illegal = 1'b1;
		endcase
		return r;
	endfunction

	// Ends at 1 ns after the next rising edge
	task automatic stepCycle();
		@(posedge clk);
		#1;
		if (inCreditReturn) begin
			returnsSeen++;
			inCredits++;
			assert (returnsSeen <= beatsSent)
			else failRun("DUT returned more input credits than beats it received");
		end
	endtask

	task automatic sendInstr(input dataT instr, input dataT rs, input dataT rt);
		issueT iss;
		while (inCredits == 0)
			stepCycle();
		iss.tag = nextTag;
		iss.instr = instr;
		iss.rsVal = rs;
		iss.rtVal = rt;
		expQ.push_back(expectedResult(iss));
		inIssue = iss;
		inValid = 1'b1;
		inCredits--;
		beatsSent++;
		nextTag++;
		stepCycle();
		inValid = 1'b0;
	endtask

	task automatic aluTests();
		foreach (aluFns[i])
			sendInstr(rType(aluFns[i], 5'(randWord())), randWord(), randWord());
		sendInstr(rType(FN_SLT, 5'd0), 32'hFFFF_FFFF, 32'h0000_0001);
		sendInstr(rType(FN_SLTU, 5'd0), 32'hFFFF_FFFF, 32'h0000_0001);
		sendInstr(rType(FN_SRAV, 5'd0), 32'hFFFF_FFE7, 32'h8000_1234); // Amount 7
		sendInstr(rType(FN_SLLV, 5'd0), 32'h0000_0123, randWord());
		foreach (immOps[i]) begin
			sendInstr(iType(immOps[i], 16'h8001), randWord(), randWord());
			sendInstr(iType(immOps[i], 16'(randWord())), randWord(), randWord());
		end
		sendInstr(iType(OP_SLTI, 16'hFFFF), 32'hFFFF_FFFE, 32'h0);
		sendInstr(iType(OP_SLTIU, 16'hFFFF), 32'hFFFF_FFFE, 32'h0);
	endtask

	task automatic hiLoPair(input logic [5:0] fn, input dataT rs, input dataT rt);
		sendInstr(rType(fn, 5'd0), rs, rt);
		sendInstr(rType(FN_MFHI, 5'd0), randWord(), randWord());
		sendInstr(rType(FN_MFLO, 5'd0), randWord(), randWord());
	endtask

	task automatic hiLoTests();
		hiLoPair(FN_MTHI, randWord(), randWord());
		hiLoPair(FN_MTLO, randWord(), randWord());
		foreach (mulDivFns[i]) begin
			hiLoPair(mulDivFns[i], randWord(), randWord());
			hiLoPair(mulDivFns[i], 32'hFFFF_FF85, 32'h0000_0007);
			hiLoPair(mulDivFns[i], 32'h0000_0064, 32'hFFFF_FFF9);
			hiLoPair(mulDivFns[i], 32'hFFFF_FFF0, 32'hFFFF_FFFD);
			hiLoPair(mulDivFns[i], randWord(), 32'h0); // Divide by zero
			hiLoPair(mulDivFns[i], 32'h8000_0010, 32'h0);
		end
		// Chain stacked behind the busy divider
		sendInstr(rType(FN_DIV, 5'd0), randWord(), randWord());
		sendInstr(rType(FN_DIVU, 5'd0), randWord(), randWord());
		sendInstr(rType(FN_MULT, 5'd0), randWord(), randWord());
		sendInstr(rType(FN_DIV, 5'd0), randWord(), randWord());
		sendInstr(rType(FN_ADDU, 5'd0), randWord(), randWord());
		sendInstr(rType(FN_MFLO, 5'd0), randWord(), randWord());
		sendInstr(rType(FN_MFHI, 5'd0), randWord(), randWord());
	endtask

	task automatic memTests();
		dataT base;
		dataT offWord;
		foreach (memOps[i]) begin
			for (int k = 0; k < 4; k++) begin
				base = randWord();
				offWord = randWord();
				sendInstr(iType(memOps[i], {offWord[15:2], 2'b00}), {base[31:2], 2'(k)},
					randWord());
			end
		end
	endtask

	task automatic illegalTests();
		sendInstr(iType(6'h3F, 16'(randWord())), randWord(), randWord());
		sendInstr(iType(6'h08, 16'(randWord())), randWord(), randWord()); // ADDI
		sendInstr(iType(6'h02, 16'(randWord())), randWord(), randWord());
		sendInstr(rType(6'h3F, 5'd0), randWord(), randWord());
		sendInstr(rType(6'h20, 5'd0), randWord(), randWord()); // ADD
		sendInstr(rType(6'h08, 5'd0), randWord(), randWord());
	endtask

	task automatic randomTests();
		int unsigned pick;
		dataT rt;
		while (beatsSent < NUM_INSTR) begin
			pick = $unsigned($random(seed));
			rt = (pick[7:4] == 4'd0) ? '0 : randWord(); // Some zero divisors
			case (pick % 10)
				0, 1, 2: sendInstr(rType(aluFns[pick[15:8] % 13], 5'(randWord())),
					randWord(), rt);
				3, 4: sendInstr(iType(immOps[pick[15:8] % 7], 16'(randWord())), randWord(), rt);
				5, 6: sendInstr(rType(hlFns[pick[15:8] % 8], 5'd0), randWord(), rt);
				7, 8: sendInstr(iType(memOps[pick[15:8] % 10], 16'(randWord())), randWord(), rt);
				default: sendInstr(randWord(), randWord(), rt);
			endcase
			if (pick[3:0] == 4'd0)
				stepCycle(); // Idle gap
		end
	endtask

	// Result check and output credit mirror
	always @(negedge clk) begin
		resultT want;
		if (outValid) begin
			assert (outMirror > 0)
			else failRun("DUT raised outValid with no output credit left");
			assert (expQ.size() > 0)
			else failRun("DUT sent a result with no instruction pending");
			want = expQ.pop_front();
			checkField("outResult.tag", 32'(outResult.tag), 32'(want.tag));
			checkField("outResult.value", outResult.value, want.value);
			checkField("outResult.byteEnable", 32'(outResult.byteEnable), 32'(want.byteEnable));
			checkField("outResult.memAccess", 32'(outResult.memAccess), 32'(want.memAccess));
			checkField("outResult.writesReg", 32'(outResult.writesReg), 32'(want.writesReg));
			checkField("outResult.addrError", 32'(outResult.addrError), 32'(want.addrError));
			checkField("outResult.illegal", 32'(outResult.illegal), 32'(want.illegal));
		end
		outMirror = outMirror - int'(outValid) + int'(prevRet); // Return counts one edge late
		prevRet = outCreditReturn;
	end

	// Downstream side hands credits back at random gaps
	initial begin
		int unsigned r;
		outCreditReturn = 1'b0;
		owed = 0;
		stall = 0;
		forever begin
			@(posedge clk);
			#1;
			r = $unsigned($random(gapSeed));
			if (outValid)
				owed++;
			outCreditReturn = 1'b0;
			if (stall > 0)
				stall--;
			else if (owed > 0 && r % 3 != 0) begin
				outCreditReturn = 1'b1;
				owed--;
			end
			if (r % 97 == 0)
				stall = 40 + r % 60; // Long stall, both queues fill
		end
	end

	initial begin
		#((RESET_CYCLES + 200 * NUM_INSTR) * 10);
		failRun("Watchdog timeout, results stopped arriving");
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		inIssue = '0;
		inCredits = IN_DEPTH;
		beatsSent = 0;
		returnsSeen = 0;
		outMirror = OUT_CREDITS;
		prevRet = 1'b0;
		nextTag = '0;
		shadowHi = '0;
		shadowLo = '0;
		repeat (RESET_CYCLES)
			stepCycle();
		arstN = 1'b1;
		stepCycle();
		aluTests();
		hiLoTests();
		memTests();
		illegalTests();
		randomTests();
		while (expQ.size() != 0)
			stepCycle();
		repeat (4)
			stepCycle();
		if (inCredits == IN_DEPTH && returnsSeen == beatsSent) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			failRun("Input credits were not all returned at the end of the run");
		end
	end

endmodule

/* verilog/creditQueue.sv */
`timescale 1ns/1ps

module creditQueue #(
	parameter int DEPTH = 4,
	parameter type payloadT = logic [31:0]
) (
	input logic clk,
	input logic arstN,
	input logic push,
	input payloadT pushData,
	input logic pop,
	output payloadT popData,
	output logic notEmpty,
	output logic full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payloadT mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic doPush;
	logic doPop;

	assign notEmpty = count != '0;
	assign full = count == CNT_W'(DEPTH);
	assign doPush = push && !full; // Sender holds a credit, so never full here
	assign doPop = pop && notEmpty;
	assign popData = mem[rdPtr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + CNT_W'(doPush) - CNT_W'(doPop);
		end
	end

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

/* verilog/execStage.sv */
`timescale 1ns/1ps

module execStage import mipsExecPkg::*; #(
	parameter int IN_DEPTH = 4,
	parameter int RES_DEPTH = 4,
	parameter int OUT_CREDITS = 4
) (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input issueT inIssue,
	output logic inCreditReturn,
	output logic outValid,
	output resultT outResult,
	input logic outCreditReturn
);

	localparam int CNT_W = $clog2(OUT_CREDITS + 1);

	issueT head;
	logic inNotEmpty;
	decodedT dec;
	dataT aluResult;
	dataT hlRead;
	logic hlBusy;
	logic hlStart;
	dataT memAddr;
	logic [3:0] memBe;
	logic memErr;
	logic issueFire;
	resultT issueResult;
	resultT resHead;
	logic resNotEmpty;
	logic resFull;
	logic outFire;
	logic [CNT_W-1:0] outCredits;

	creditQueue #(.DEPTH(IN_DEPTH), .payloadT(issueT)) u_inQueue (
		.clk(clk),
		.arstN(arstN),
		.push(inValid),
		.pushData(inIssue),
		.pop(issueFire),
		.popData(head),
		.notEmpty(inNotEmpty),
		.full()
	);

	instrDecoder u_instrDecoder (
		.instr(head.instr),
		.dec(dec)
	);

	intAlu u_intAlu (
		.dec(dec),
		.rsVal(head.rsVal),
		.rtVal(head.rtVal),
		.aluResult(aluResult)
	);

	hiLoUnit u_hiLoUnit (
		.clk(clk),
		.arstN(arstN),
		.start(hlStart),
		.dec(dec),
		.rsVal(head.rsVal),
		.rtVal(head.rtVal),
		.readVal(hlRead),
		.busy(hlBusy)
	);

	memAddrUnit u_memAddrUnit (
		.dec(dec),
		.rsVal(head.rsVal),
		.addr(memAddr),
		.byteEnable(memBe),
		.addrError(memErr)
	);

	// Hold HI/LO ops while a divide runs, and wait for result queue room
	assign issueFire = inNotEmpty && !resFull && !(dec.opClass == CLASS_HILO && hlBusy);
	assign hlStart = issueFire && (dec.opClass == CLASS_HILO);

	always_comb begin
		issueResult = '0;
		issueResult.tag = head.tag;
		issueResult.writesReg = dec.writesReg;
		case (dec.opClass)
			CLASS_ALU: issueResult.value = aluResult;
			CLASS_HILO: issueResult.value = hlRead;
			CLASS_MEM: begin
				issueResult.value = memAddr;
				issueResult.byteEnable = memBe;
				issueResult.memAccess = 1'b1;
				issueResult.addrError = memErr;
			end
			default: issueResult.illegal = 1'b1;
		endcase
	end

	creditQueue #(.DEPTH(RES_DEPTH), .payloadT(resultT)) u_resQueue (
		.clk(clk),
		.arstN(arstN),
		.push(issueFire),
		.pushData(issueResult),
		.pop(outFire),
		.popData(resHead),
		.notEmpty(resNotEmpty),
		.full(resFull)
	);

	assign outFire = resNotEmpty && (outCredits != '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			inCreditReturn <= 1'b0;
			outValid <= 1'b0;
			outCredits <= CNT_W'(OUT_CREDITS);
		end else begin
			inCreditReturn <= issueFire; // One credit per popped entry
			outValid <= outFire;
			outCredits <= outCredits - CNT_W'(outFire) + CNT_W'(outCreditReturn);
		end
	end

	always_ff @(posedge clk) begin
		if (outFire)
			outResult <= resHead;
	end

endmodule

/* verilog/hiLoUnit.sv */
`timescale 1ns/1ps

module hiLoUnit import mipsExecPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	input decodedT dec,
	input dataT rsVal,
	input dataT rtVal,
	output dataT readVal,
	output logic busy
);

	localparam logic [5:0] LAST_STEP = 6'd32;

	dataT hi;
	dataT lo;
	logic isSigned;
	logic [63:0] mulA;
	logic [63:0] mulB;
	logic [63:0] product;
	logic divStart;
	logic [5:0] stepCnt;
	dataT divisor;
	dataT quo;
	dataT rem;
	logic negQ;
	logic negR;
	logic [32:0] trialRem;
	logic fitsDivisor;

	assign isSigned = dec.hiLoOp inside {HL_MULT, HL_DIV};

	// Sign-extend for signed multiply, low 64 bits of the product are exact
	assign mulA = {{32{isSigned & rsVal[31]}}, rsVal};
	assign mulB = {{32{isSigned & rtVal[31]}}, rtVal};
	assign product = mulA * mulB;

	assign divStart = start && (dec.hiLoOp inside {HL_DIV, HL_DIVU});
	assign trialRem = {rem, quo[31]}; // Dividend bits shift out of quo
	assign fitsDivisor = trialRem >= {1'b0, divisor};

	always_comb begin
		case (dec.hiLoOp)
			HL_MFHI: readVal = hi;
			HL_MFLO: readVal = lo;
			default: readVal = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hi <= '0;
			lo <= '0;
			busy <= 1'b0;
			stepCnt <= '0;
		end else if (busy) begin
			if (stepCnt == LAST_STEP) begin
				busy <= 1'b0;
				hi <= negR ? -rem : rem; // Remainder takes dividend sign
				lo <= negQ ? -quo : quo;
			end else begin
				stepCnt <= stepCnt + 6'd1;
			end
		end else if (start) begin
			case (dec.hiLoOp)
				HL_MTHI: hi <= rsVal;
				HL_MTLO: lo <= rsVal;
				HL_MULT, HL_MULTU: begin
					hi <= product[63:32];
					lo <= product[31:0];
				end
				HL_DIV, HL_DIVU: begin
					busy <= 1'b1;
					stepCnt <= '0;
				end
				default: ;
			endcase
		end
	end

	// Restoring divider on magnitudes
	always_ff @(posedge clk) begin
		if (divStart) begin
			divisor <= (isSigned && rtVal[31]) ? -rtVal : rtVal;
			quo <= (isSigned && rsVal[31]) ? -rsVal : rsVal;
			rem <= '0;
			// No quotient negation on divide by zero, LO stays all ones
			negQ <= isSigned && (rsVal[31] ^ rtVal[31]) && (rtVal != '0);
			negR <= isSigned && rsVal[31];
		end else if (busy && stepCnt != LAST_STEP) begin
			quo <= {quo[30:0], fitsDivisor};
			rem <= fitsDivisor ? (trialRem[31:0] - divisor) : trialRem[31:0];
		end
	end

endmodule

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import mipsExecPkg::*; (
	input dataT instr,
	output decodedT dec
);

	logic [5:0] opcode;
	logic [5:0] funct;
	dataT immSE;
	dataT immZE;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign immSE = {{16{instr[15]}}, instr[15:0]};
	assign immZE = {16'h0000, instr[15:0]};

	always_comb begin
		dec = '0;
		dec.opClass = CLASS_ILLEGAL;
		dec.aluOp = ALU_ADD;
		dec.hiLoOp = HL_NONE;
		dec.memSize = MEM_WORD;
		dec.imm = immSE;
		dec.shamt = instr[10:6];
		if (opcode == OP_SPECIAL) begin
			case (funct)
				FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
				FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:
					dec.opClass = CLASS_ALU;
				FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU:
					dec.opClass = CLASS_HILO;
				default: dec.opClass = CLASS_ILLEGAL;
			endcase
			case (funct)
				FN_SUBU: dec.aluOp = ALU_SUB;
				FN_AND: dec.aluOp = ALU_AND;
				FN_OR: dec.aluOp = ALU_OR;
				FN_XOR: dec.aluOp = ALU_XOR;
				FN_SLT: dec.aluOp = ALU_SLT;
				FN_SLTU: dec.aluOp = ALU_SLTU;
				FN_SLL, FN_SLLV: dec.aluOp = ALU_SLL;
				FN_SRL, FN_SRLV: dec.aluOp = ALU_SRL;
				FN_SRA, FN_SRAV: dec.aluOp = ALU_SRA;
				default: dec.aluOp = ALU_ADD;
			endcase
			case (funct)
				FN_MFHI: dec.hiLoOp = HL_MFHI;
				FN_MFLO: dec.hiLoOp = HL_MFLO;
				FN_MTHI: dec.hiLoOp = HL_MTHI;
				FN_MTLO: dec.hiLoOp = HL_MTLO;
				FN_MULT: dec.hiLoOp = HL_MULT;
				FN_MULTU: dec.hiLoOp = HL_MULTU;
				FN_DIV: dec.hiLoOp = HL_DIV;
				FN_DIVU: dec.hiLoOp = HL_DIVU;
				default: dec.hiLoOp = HL_NONE;
			endcase
			dec.shiftByRs = funct inside {FN_SLLV, FN_SRLV, FN_SRAV};
			dec.writesReg = (dec.opClass == CLASS_ALU) || (funct inside {FN_MFHI, FN_MFLO});
		end else begin
			case (opcode)
				OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
					dec.opClass = CLASS_ALU;
				OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_SB, OP_SH, OP_SW:
					dec.opClass = CLASS_MEM;
				default: dec.opClass = CLASS_ILLEGAL;
			endcase
			case (opcode)
				OP_SLTI: dec.aluOp = ALU_SLT;
				OP_SLTIU: dec.aluOp = ALU_SLTU; // Sign-extended imm, unsigned compare
				OP_ANDI: dec.aluOp = ALU_AND;
				OP_ORI: dec.aluOp = ALU_OR;
				OP_XORI: dec.aluOp = ALU_XOR;
				OP_LUI: dec.aluOp = ALU_LUI;
				default: dec.aluOp = ALU_ADD;
			endcase
			case (opcode)
				OP_LB, OP_LBU, OP_SB: dec.memSize = MEM_BYTE;
				OP_LH, OP_LHU, OP_SH: dec.memSize = MEM_HALF;
				OP_LWL: dec.memSize = MEM_WORD_LEFT;
				OP_LWR: dec.memSize = MEM_WORD_RIGHT;
				default: dec.memSize = MEM_WORD;
			endcase
			if (opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
				dec.imm = immZE; // Logic ops zero-extend
			dec.useImm = 1'b1;
			// Stores have opcode bit 3 set
			dec.writesReg = (dec.opClass == CLASS_ALU) || (dec.opClass == CLASS_MEM && !opcode[3]);
		end
	end

endmodule

/* verilog/intAlu.sv */
`timescale 1ns/1ps

module intAlu import mipsExecPkg::*; (
	input decodedT dec,
	input dataT rsVal,
	input dataT rtVal,
	output dataT aluResult
);

	dataT opB;
	logic [4:0] shAmt;

	assign opB = dec.useImm ? dec.imm : rtVal;
	assign shAmt = dec.shiftByRs ? rsVal[4:0] : dec.shamt; // Only low five bits of rs

	always_comb begin
		case (dec.aluOp)
			ALU_ADD: aluResult = rsVal + opB;
			ALU_SUB: aluResult = rsVal - opB;
			ALU_AND: aluResult = rsVal & opB;
			ALU_OR: aluResult = rsVal | opB;
			ALU_XOR: aluResult = rsVal ^ opB;
			ALU_LUI: aluResult = {opB[15:0], 16'h0000};
			ALU_SLT: aluResult = {31'b0, $signed(rsVal) < $signed(opB)};
			ALU_SLTU: aluResult = {31'b0, rsVal < opB};
			// Shifts always act on rt
			ALU_SLL: aluResult = rtVal << shAmt;
			ALU_SRL: aluResult = rtVal >> shAmt;
			ALU_SRA: aluResult = $signed(rtVal) >>> shAmt;
			default: aluResult = '0;
		endcase
	end

endmodule

/* verilog/memAddrUnit.sv */
`timescale 1ns/1ps

module memAddrUnit import mipsExecPkg::*; (
	input decodedT dec,
	input dataT rsVal,
	output dataT addr,
	output logic [3:0] byteEnable,
	output logic addrError
);

	dataT effAddr;
	logic [1:0] offset;

	assign effAddr = rsVal + dec.imm;
	assign offset = effAddr[1:0];
	assign addr = {effAddr[31:2], 2'b00}; // Word aligned

	always_comb begin
		addrError = 1'b0;
		case (dec.memSize)
			MEM_BYTE: byteEnable = 4'b0001 << offset;
			MEM_HALF: begin
				case (offset)
					2'd0: byteEnable = 4'b0011;
					2'd1: byteEnable = 4'b0110;
					2'd2: byteEnable = 4'b1100;
					default: begin
						byteEnable = 4'b0000; // Crosses the word
						addrError = 1'b1;
					end
				endcase
			end
			MEM_WORD_LEFT: begin
				case (offset)
					2'd0: byteEnable = 4'b1111;
					2'd1: byteEnable = 4'b1110;
					2'd2: byteEnable = 4'b1100;
					default: byteEnable = 4'b1000;
				endcase
			end
			MEM_WORD_RIGHT: begin
				case (offset)
					2'd0: byteEnable = 4'b0001;
					2'd1: byteEnable = 4'b0011;
					2'd2: byteEnable = 4'b0111;
					default: byteEnable = 4'b1111;
				endcase
			end
			default: byteEnable = 4'b1111;
		endcase
	end

endmodule

/* verilog/mipsExecPkg.sv */
package mipsExecPkg;

	typedef logic [31:0] dataT;

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0A;
	localparam logic [5:0] OP_SLTIU   = 6'h0B;
	localparam logic [5:0] OP_ANDI    = 6'h0C;
	localparam logic [5:0] OP_ORI     = 6'h0D;
	localparam logic [5:0] OP_XORI    = 6'h0E;
	localparam logic [5:0] OP_LUI     = 6'h0F;
	localparam logic [5:0] OP_LB      = 6'h20;
	localparam logic [5:0] OP_LH      = 6'h21;
	localparam logic [5:0] OP_LWL     = 6'h22;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_LHU     = 6'h25;
	localparam logic [5:0] OP_LWR     = 6'h26;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SH      = 6'h29;
	localparam logic [5:0] OP_SW      = 6'h2B;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_SRL   = 6'h02;
	localparam logic [5:0] FN_SRA   = 6'h03;
	localparam logic [5:0] FN_SLLV  = 6'h04;
	localparam logic [5:0] FN_SRLV  = 6'h06;
	localparam logic [5:0] FN_SRAV  = 6'h07;
	localparam logic [5:0] FN_MFHI  = 6'h10;
	localparam logic [5:0] FN_MTHI  = 6'h11;
	localparam logic [5:0] FN_MFLO  = 6'h12;
	localparam logic [5:0] FN_MTLO  = 6'h13;
	localparam logic [5:0] FN_MULT  = 6'h18;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_DIV   = 6'h1A;
	localparam logic [5:0] FN_DIVU  = 6'h1B;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_SLT   = 6'h2A;
	localparam logic [5:0] FN_SLTU  = 6'h2B;

	typedef enum logic [1:0] {CLASS_ALU, CLASS_HILO, CLASS_MEM, CLASS_ILLEGAL} opClassT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} aluOpT;

	typedef enum logic [3:0] {
		HL_NONE, HL_MFHI, HL_MFLO, HL_MTHI, HL_MTLO,
		HL_MULT, HL_MULTU, HL_DIV, HL_DIVU
	} hiLoOpT;

	typedef enum logic [2:0] {
		MEM_BYTE, MEM_HALF, MEM_WORD, MEM_WORD_LEFT, MEM_WORD_RIGHT
	} memSizeT;

	typedef struct packed {
		logic [7:0] tag;
		dataT instr;
		dataT rsVal;
		dataT rtVal;
	} issueT;

	typedef struct packed {
		logic [7:0] tag;
		dataT value;
		logic [3:0] byteEnable;
		logic memAccess;
		logic writesReg;
		logic addrError;
		logic illegal;
	} resultT;

	typedef struct packed {
		opClassT opClass;
		aluOpT aluOp;
		hiLoOpT hiLoOp;
		memSizeT memSize;
		logic useImm; // Operand B is the immediate
		dataT imm;
		logic [4:0] shamt;
		logic shiftByRs; // Variable shift, amount from rs[4:0]
		logic writesReg;
	} decodedT;

endpackage
